// File: Makefile
SRCS := $(filter %.sv,$(shell cat avl_bus_n21.f)) include/avl_bus_macros.svh

# Round-robin and priority builds, each run must exit cleanly
run: obj_rr/Vavl_bus_n21_tb obj_prio/Vavl_bus_n21_tb
	./obj_rr/Vavl_bus_n21_tb
	./obj_prio/Vavl_bus_n21_tb

obj_%/Vavl_bus_n21_tb: $(SRCS) avl_bus_n21.f
	verilator --binary --timing --assert -f avl_bus_n21.f \
	  --top-module avl_bus_n21_tb \
	  -GARB_METHOD=$(if $(filter prio,$*),1,0) \
	  --Mdir obj_$* -o Vavl_bus_n21_tb

clean:
	rm -rf obj_rr obj_prio

.PHONY: run clean

// File: avl_bus_n21.f
+incdir+include
rtl/avl_bus_pkg.sv
rtl/avl_bus_priority_encoder.sv
rtl/avl_bus_n21_arb.sv
rtl/avl_bus_master_port.sv
rtl/avl_bus_cmd_mux.sv
rtl/avl_bus_rsp_router.sv
rtl/avl_bus_n21_top.sv
dv/avl_bus_mem_model.sv
dv/avl_bus_n21_tb.sv

// File: dv/avl_bus_mem_model.sv
`include "avl_bus_macros.svh"

module avl_bus_mem_model #(
  parameter int          LATENCY = 3,             // Accept edge to readdatavalid, at least 2
  parameter logic [31:0] SEED    = 32'hac664660
) (
  input  logic                  clk,
  input  logic                  rest,
  input  avl_bus_pkg::avl_cmd_t s_cmd,
  output logic                  s_ready,
  output avl_bus_pkg::avl_rsp_t s_rsp
);

  localparam int ADDR_W = `AVL_ADDR_W;

  logic [31:0]        lcg_state;             // Ready pattern generator
  logic [LATENCY-1:0] pipe_vld;              // Read beats in flight
  logic [ADDR_W-1:0]  pipe_addr [LATENCY];
  logic               rd_acc;                // Read taken on this edge
  logic [ADDR_W-1:0]  rd_addr;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    s_ready   = 1'b0;
    s_rsp     = '0;
    pipe_vld  = '0;
    lcg_state = SEED;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slave behavior, sampled on the edge and driven just after it
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    rd_acc  = rest && s_ready && s_cmd.read;  // Writes are simply absorbed
    rd_addr = s_cmd.address;
    #1;
    if (!rest) begin
      pipe_vld = '0;
      s_rsp    = '0;
      s_ready  = 1'b0;
    end else begin
      pipe_vld = {pipe_vld[LATENCY-2:0], rd_acc};
      for (int i = LATENCY - 1; i > 0; i--) begin
        pipe_addr[i] = pipe_addr[i-1];
      end
      pipe_addr[0] = rd_addr;
      s_rsp.readdatavalid = pipe_vld[LATENCY-1];
      s_rsp.readdata      = pipe_vld[LATENCY-1] ?
                            avl_bus_n21_tb.ref_data(pipe_addr[LATENCY-1]) : '0;
      lcg_state = lcg_next(lcg_state);
      s_ready   = (lcg_state[31:30] != 2'b00);  // Ready about three cycles in four
    end
  end

endmodule

// File: dv/avl_bus_n21_tb.sv
`include "avl_bus_macros.svh"

module avl_bus_n21_tb #(
  parameter int ARB_METHOD = 0  // 0 round robin, 1 fixed priority
);

  localparam int N           = `AVL_MASTER_NUM;
  localparam int ID_W        = $clog2(N);
  localparam int ADDR_W      = `AVL_ADDR_W;
  localparam int DATA_W      = `AVL_DATA_W;
  localparam int CNT_W       = avl_bus_pkg::BURST_CNT_W;
  localparam int TXN_NUM     = 40;     // Commands per master, a burst counts once
  localparam int BUSY_LIMIT  = 300;    // Cycles a slot may stay full
  localparam int STIM_LIMIT  = 20000;
  localparam int DRAIN_LIMIT = 500;

  logic                  clk;
  logic                  rest;
  logic [N-1:0]          m_load;
  avl_bus_pkg::avl_cmd_t m_cmd [N];
  logic [N-1:0]          m_busy;
  avl_bus_pkg::avl_rsp_t m_rsp [N];
  avl_bus_pkg::avl_cmd_t s_cmd;
  logic                  s_ready;
  avl_bus_pkg::avl_rsp_t s_rsp;

  logic [31:0]           lcg_state;
  avl_bus_pkg::avl_cmd_t last_load [N];   // What each full slot must present
  int                    txn_done [N];
  int                    beats_left [N];  // Burst beats still to load
  logic [ADDR_W-1:0]     exp_rd [N][$];   // Accepted reads awaiting data, per master
  int                    busy_cnt [N];
  logic [N-1:0]          just_taken;      // Slot accepted on the last edge
  logic [N-1:0]          exp_busy;        // Model of the full slots
  logic [N-1:0]          loaded;          // Loads sampled on the coming edge
  int                    last_id;         // Model of the rotation pointer
  int                    lock_id;
  int                    lock_left;       // Burst beats still owed to lock_id
  int                    accept_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected read data, every address bit matters
  function automatic logic [DATA_W-1:0] ref_data(input logic [ADDR_W-1:0] addr);
    return {addr, ~addr} ^ (32'(addr) * 32'h9e37_79b1);
  endfunction

  // Grant rule: search from one past the last grant, or from zero for priority
  function automatic int exp_grant(input logic [N-1:0] req, input int last);
    int start;
    start = (ARB_METHOD == 1) ? 0 : (last + 1) % N;
    for (int k = 0; k < N; k++) begin
      if (req[(start + k) % N]) begin
        return (start + k) % N;
      end
    end
    return -1;
  endfunction

  function automatic logic all_issued();
    for (int i = 0; i < N; i++) begin
      if (txn_done[i] < TXN_NUM || beats_left[i] > 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic drained();
    if (m_busy != '0) begin
      return 1'b0;
    end
    for (int i = 0; i < N; i++) begin
      if (exp_rd[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master stimulus, one call per cycle just after the edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_masters();
    logic [31:0] r;
    int          n;
    for (int i = 0; i < N; i++) begin
      m_load[i] = 1'b0;
      if (!m_busy[i] && (beats_left[i] > 0 || txn_done[i] < TXN_NUM)) begin
        lcg_state = lcg_next(lcg_state);
        r         = lcg_state;
        // First half keeps every slot full, then loads come at random
        if (txn_done[i] < TXN_NUM / 2 || r[3]) begin
          m_cmd[i]           = '0;
          m_cmd[i].address   = {ID_W'(i), r[16 +: ADDR_W-ID_W]};  // Owner id on top
          m_cmd[i].writedata = {r[15:0], r[31:16]} ^ 32'(i);
          if (beats_left[i] > 0) begin
            m_cmd[i].write = 1'b1;  // Burst continuation
            beats_left[i]--;
          end else begin
            txn_done[i]++;
            case (r[5:4])
              2'd0, 2'd1: m_cmd[i].read = 1'b1;
              2'd2: begin
                m_cmd[i].write                = 1'b1;
                m_cmd[i].begin_burst_transfer = r[6];  // Count of one is still single
                m_cmd[i].burst_count          = r[6] ? CNT_W'(1) : '0;
              end
              default: begin
                n                             = 2 + int'(r[2:0]) % 7;  // 2 to 8 beats
                m_cmd[i].write                = 1'b1;
                m_cmd[i].begin_burst_transfer = 1'b1;
                m_cmd[i].burst_count          = CNT_W'(n);
                beats_left[i]                 = n - 1;
              end
            endcase
          end
          last_load[i] = m_cmd[i];
          m_load[i]    = 1'b1;
        end
      end
    end
  endtask

  avl_bus_n21_top #(
    .ARB_METHOD(ARB_METHOD),
    .MASTER_NUM(N)
  ) dut (
    .clk    (clk),
    .rest   (rest),
    .m_load (m_load),
    .m_cmd  (m_cmd),
    .m_busy (m_busy),
    .m_rsp  (m_rsp),
    .s_cmd  (s_cmd),
    .s_ready(s_ready),
    .s_rsp  (s_rsp)
  );

  avl_bus_mem_model #(
    .LATENCY(3),
    .SEED   (32'hac664660)
  ) u_mem (
    .clk    (clk),
    .rest   (rest),
    .s_cmd  (s_cmd),
    .s_ready(s_ready),
    .s_rsp  (s_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checker, all DUT outputs are settled at the falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    int                exp_id;
    if (!rest) begin
      last_id    = N - 1;  // Master 0 goes first after reset
      lock_left  = 0;
      lock_id    = 0;
      accept_cnt = 0;
      just_taken = '0;
      exp_busy   = '0;
      loaded     = '0;
      assert (m_busy == '0)
        else stop_on_error($sformatf("[FAIL] m_busy got %h expected 0", m_busy));
      assert (s_cmd == '0)
        else stop_on_error($sformatf("[FAIL] s_cmd got %h expected 0", s_cmd));
      for (int i = 0; i < N; i++) begin
        busy_cnt[i] = 0;
        assert (!m_rsp[i].readdatavalid)
          else stop_on_error($sformatf("[FAIL] m_rsp[%0d].readdatavalid got 1 expected 0", i));
      end
    end else begin
      exp_busy = (exp_busy & ~just_taken) | loaded;  // Slot state after the last edge
      assert (m_busy == exp_busy)
        else stop_on_error($sformatf("[FAIL] m_busy got %h expected %h", m_busy, exp_busy));
      for (int i = 0; i < N; i++) begin
        if (m_rsp[i].readdatavalid) begin
          assert (exp_rd[i].size() > 0)
            else stop_on_error($sformatf("Master %0d got read data with no read pending", i));
          addr = exp_rd[i].pop_front();  // In that master's issue order
          assert (m_rsp[i].readdata == ref_data(addr))
            else stop_on_error($sformatf("[FAIL] m_rsp[%0d].readdata got %h expected %h",
                                         i, m_rsp[i].readdata, ref_data(addr)));
        end
        busy_cnt[i] = m_busy[i] ? busy_cnt[i] + 1 : 0;
        assert (busy_cnt[i] < BUSY_LIMIT)
          else stop_on_error($sformatf("Master %0d command was never accepted", i));
      end
      just_taken = '0;
      loaded     = m_load;
      if (s_ready && (s_cmd.read || s_cmd.write)) begin
        id = s_cmd.address[ADDR_W-1 -: ID_W];
        assert (exp_busy[id])
          else stop_on_error($sformatf("Master %0d slot was empty when its command was taken",
                                       id));
        assert (s_cmd == last_load[id])
          else stop_on_error($sformatf("[FAIL] s_cmd got %h expected %h", s_cmd, last_load[id]));
        if (lock_left > 0) begin
          // Burst keeps the grant whatever else requests
          assert (int'(id) == lock_id)
            else stop_on_error($sformatf("[FAIL] s_cmd owner got %h expected %h", id, lock_id));
          lock_left--;
          if (lock_left == 0) begin
            last_id = id;
          end
        end else begin
          exp_id = exp_grant(exp_busy, last_id);
          assert (int'(id) == exp_id)
            else stop_on_error($sformatf("[FAIL] grant got %h expected %h", id, exp_id));
          if (s_cmd.begin_burst_transfer && s_cmd.burst_count > 1) begin
            lock_id   = id;
            lock_left = int'(s_cmd.burst_count) - 1;
          end else begin
            last_id = id;
          end
        end
        if (s_cmd.read) begin
          exp_rd[id].push_back(s_cmd.address);
        end
        just_taken[id] = 1'b1;
        accept_cnt++;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset, stimulus and end of run
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int cyc;
    rest      = 1'b0;
    m_load    = '0;
    lcg_state = 32'hac664660;
    for (int i = 0; i < N; i++) begin
      m_cmd[i]      = '0;
      last_load[i]  = '0;
      txn_done[i]   = 0;
      beats_left[i] = 0;
    end
    repeat (16) @(posedge clk);
    #1 rest = 1'b1;

    cyc = 0;
    while (!all_issued() && cyc < STIM_LIMIT) begin
      @(posedge clk);
      #1;
      drive_masters();
      cyc++;
    end
    @(posedge clk);  // Last load is sampled here
    #1 m_load = '0;
    if (!all_issued()) begin
      stop_on_error("Masters could not issue all commands before the timeout");
    end

    cyc = 0;
    while (!drained() && cyc < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (drained()) begin
      $display("Accepted %0d beats", accept_cnt);
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_on_error("Commands or read data still pending at the drain timeout");
    end
  end

endmodule

// File: include/avl_bus_macros.svh
`ifndef AVL_BUS_MACROS_SVH
`define AVL_BUS_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AVL_ADDR_W          16  // Byte address bits
`define AVL_DATA_W          32  // Read and write data bits

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arbiter sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AVL_MASTER_NUM      4   // Default master count, 2 to 16
`define AVL_BURST_MAX_COUNT 8   // Longest write burst in beats

// Outstanding reads the router can track
`define AVL_OWNER_DEPTH     8

`endif

// File: rtl/avl_bus_cmd_mux.sv
`include "avl_bus_macros.svh"

module avl_bus_cmd_mux #(
  parameter int MASTER_NUM = `AVL_MASTER_NUM
) (
  input  logic [$clog2(MASTER_NUM)-1:0] sel,
  input  avl_bus_pkg::avl_cmd_t         slot_cmd [MASTER_NUM],
  input  logic                          s_ready,
  output avl_bus_pkg::avl_cmd_t         s_cmd,
  output logic [MASTER_NUM-1:0]         taken,       // One-hot, empties the winner
  output logic                          accept,      // Any beat accepted
  output logic                          owner_push,  // Record a read owner
  output logic [$clog2(MASTER_NUM)-1:0] owner_id
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign s_cmd = slot_cmd[sel];  // Empty winner forwards a no-op

  // A beat counts only when it carries a real operation
  assign accept = s_ready && (s_cmd.read || s_cmd.write);
  assign taken  = accept ? (MASTER_NUM'(1) << sel) : '0;

  // Reads need their issuer remembered for the response path
  assign owner_push = accept && s_cmd.read;
  assign owner_id   = sel;

endmodule

// File: rtl/avl_bus_master_port.sv
module avl_bus_master_port (
  input  logic                  clk,
  input  logic                  rest,
  input  logic                  load,      // Strobe from the master
  input  avl_bus_pkg::avl_cmd_t cmd_in,
  input  logic                  taken,     // Slot won and accepted downstream
  output logic                  busy,
  output avl_bus_pkg::avl_cmd_t slot_cmd,  // Zero while empty
  input  avl_bus_pkg::avl_rsp_t rsp_in,    // Routed read beat
  output avl_bus_pkg::avl_rsp_t rsp_out
);

  avl_bus_pkg::slot_state_e state;
  avl_bus_pkg::avl_cmd_t    cmd_q;   // Stored command
  logic                     vld_q;   // Response strobe stage
  logic [avl_bus_pkg::DATA_W-1:0] data_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command slot
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state <= avl_bus_pkg::SLOT_EMPTY;
    end else if (taken) begin
      state <= avl_bus_pkg::SLOT_EMPTY;  // Leaves on the accept edge
    end else if (load) begin
      state <= avl_bus_pkg::SLOT_FULL;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cmd_q <= cmd_in;
    end
  end

  assign busy     = (state == avl_bus_pkg::SLOT_FULL);
  assign slot_cmd = busy ? cmd_q : '0;  // Empty slot looks like a no-op

  // One register stage toward the master
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rsp_in.readdatavalid;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_in.readdatavalid) begin
      data_q <= rsp_in.readdata;
    end
  end

  always_comb begin
    rsp_out.readdatavalid = vld_q;
    rsp_out.readdata      = data_q;
  end

  // Master must wait for busy to clear before reloading
  a_no_load_busy: assert property (@(posedge clk) disable iff (!rest)
    load |-> !busy)
    else $error("master_port: load while busy");

endmodule

// File: rtl/avl_bus_n21_arb.sv
`include "avl_bus_macros.svh"

module avl_bus_n21_arb #(
  parameter int ARB_METHOD = 0,               // 0 round robin, 1 fixed priority
  parameter int MASTER_NUM = `AVL_MASTER_NUM  // 2 to 16
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic [MASTER_NUM-1:0]         request,
  input  avl_bus_pkg::avl_cmd_t         avl_out_cmd,            // Command seen by the slave
  input  logic                          avl_out_request_ready,  // Beat accepted this cycle
  output logic [$clog2(MASTER_NUM)-1:0] sel
);

  localparam int SEL_W = $clog2(MASTER_NUM);
  localparam int CNT_W = avl_bus_pkg::BURST_CNT_W;

  logic [CNT_W-1:0]      lock_cnt;     // Burst beats still owed to held_sel
  logic [SEL_W-1:0]      held_sel;     // Grant frozen for the burst
  logic [SEL_W-1:0]      now_sel;      // Fresh arbitration result
  logic [MASTER_NUM-1:0] encoder_in;
  logic [SEL_W-1:0]      encoder_out;
  logic                  accept_beat;  // Valid command taken by the slave
  logic                  burst_start;  // First beat of a multi-beat burst
  logic                  grant_done;   // Grant finished, rotation may advance

  assign accept_beat = avl_out_request_ready && (avl_out_cmd.read || avl_out_cmd.write);
  assign burst_start = accept_beat && (lock_cnt == '0) &&
                       avl_out_cmd.begin_burst_transfer && (avl_out_cmd.burst_count > 1);
  assign grant_done  = accept_beat && ((lock_cnt == CNT_W'(1)) ||
                                       ((lock_cnt == '0) && !burst_start));

  assign sel = (lock_cnt != '0) ? held_sel : now_sel;  // Locked bursts ignore other requests

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Burst lock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      lock_cnt <= '0;
      held_sel <= '0;
    end else if (burst_start) begin
      lock_cnt <= avl_out_cmd.burst_count - 1'b1;  // First beat already gone
      held_sel <= sel;
    end else if (accept_beat && (lock_cnt != '0)) begin
      lock_cnt <= lock_cnt - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request ordering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  if (ARB_METHOD == 0) begin : gen_rr
    logic [SEL_W-1:0]        last_sel;  // Last completed grant
    logic [SEL_W-1:0]        base;      // Search starts here
    logic [2*MASTER_NUM-1:0] req_rot;
    logic [SEL_W:0]          abs_sum;

    // All ones after reset so master 0 is searched first
    always_ff @(posedge clk or negedge rest) begin
      if (!rest) begin
        last_sel <= '1;
      end else if (grant_done) begin
        last_sel <= sel;
      end
    end

    assign base       = (last_sel >= SEL_W'(MASTER_NUM - 1)) ? '0 : last_sel + 1'b1;
    assign req_rot    = {request, request} >> base;  // Rotate so base sits at bit 0
    assign encoder_in = req_rot[MASTER_NUM-1:0];

    // Map the rotated index back to a master number
    assign abs_sum = {1'b0, encoder_out} + {1'b0, base};
    assign now_sel = (abs_sum >= (SEL_W+1)'(MASTER_NUM)) ?
                     SEL_W'(abs_sum - (SEL_W+1)'(MASTER_NUM)) : abs_sum[SEL_W-1:0];
  end else begin : gen_prio
    assign encoder_in = request;  // Lowest index wins outright
    assign now_sel    = encoder_out;
  end

  avl_bus_priority_encoder #(
    .SIGN_WIDTH(MASTER_NUM)
  ) u_encoder (
    .in (encoder_in),
    .out(encoder_out)
  );

  // Locked slot may only feed plain write beats of its burst
  a_lock_write_only: assert property (@(posedge clk) disable iff (!rest)
    ((lock_cnt != '0) && accept_beat) |->
      (avl_out_cmd.write && !avl_out_cmd.read && !avl_out_cmd.begin_burst_transfer))
    else $error("arb: non-continuation beat during burst lock");

endmodule

// File: rtl/avl_bus_n21_top.sv
`include "avl_bus_macros.svh"

module avl_bus_n21_top #(
  parameter int ARB_METHOD = 0,               // 0 round robin, 1 fixed priority
  parameter int MASTER_NUM = `AVL_MASTER_NUM
) (
  input  logic                  clk,
  input  logic                  rest,
  input  logic [MASTER_NUM-1:0] m_load,
  input  avl_bus_pkg::avl_cmd_t m_cmd [MASTER_NUM],
  output logic [MASTER_NUM-1:0] m_busy,
  output avl_bus_pkg::avl_rsp_t m_rsp [MASTER_NUM],
  output avl_bus_pkg::avl_cmd_t s_cmd,
  input  logic                  s_ready,
  input  avl_bus_pkg::avl_rsp_t s_rsp
);

  localparam int SEL_W = $clog2(MASTER_NUM);

  avl_bus_pkg::avl_cmd_t slot_cmd [MASTER_NUM];
  avl_bus_pkg::avl_rsp_t rsp_in   [MASTER_NUM];
  logic [MASTER_NUM-1:0] request;  // Full slots
  logic [MASTER_NUM-1:0] taken;
  logic [SEL_W-1:0]      sel;
  logic [SEL_W-1:0]      owner_id;
  logic                  accept;
  logic                  owner_push;

  assign m_busy = request;  // Full slot both blocks the master and requests

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master slots
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < MASTER_NUM; i++) begin : gen_port
    avl_bus_master_port u_port (
      .clk     (clk),
      .rest    (rest),
      .load    (m_load[i]),
      .cmd_in  (m_cmd[i]),
      .taken   (taken[i]),
      .busy    (request[i]),
      .slot_cmd(slot_cmd[i]),
      .rsp_in  (rsp_in[i]),
      .rsp_out (m_rsp[i])
    );
  end

  // Accepted beat feeds the lock and rotation state
  avl_bus_n21_arb #(
    .ARB_METHOD(ARB_METHOD),
    .MASTER_NUM(MASTER_NUM)
  ) u_arb (
    .clk                  (clk),
    .rest                 (rest),
    .request              (request),
    .avl_out_cmd          (s_cmd),
    .avl_out_request_ready(accept),
    .sel                  (sel)
  );

  avl_bus_cmd_mux #(
    .MASTER_NUM(MASTER_NUM)
  ) u_mux (
    .sel       (sel),
    .slot_cmd  (slot_cmd),
    .s_ready   (s_ready),
    .s_cmd     (s_cmd),
    .taken     (taken),
    .accept    (accept),
    .owner_push(owner_push),
    .owner_id  (owner_id)
  );

  avl_bus_rsp_router #(
    .MASTER_NUM(MASTER_NUM)
  ) u_router (
    .clk       (clk),
    .rest      (rest),
    .owner_push(owner_push),
    .owner_id  (owner_id),
    .s_rsp     (s_rsp),
    .rsp_out   (rsp_in)
  );

endmodule

// File: rtl/avl_bus_pkg.sv
`include "avl_bus_macros.svh"

package avl_bus_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_W      = `AVL_ADDR_W;
  localparam int DATA_W      = `AVL_DATA_W;
  localparam int BURST_CNT_W = $clog2(`AVL_BURST_MAX_COUNT) + 1;  // Holds the max itself

  // Command toward the slave
  // All zero is a no-op
  typedef struct packed {
    logic                   read;                  // Single-beat read
    logic                   write;                 // Write beat
    logic                   begin_burst_transfer;  // First beat of a burst
    logic [BURST_CNT_W-1:0] burst_count;           // Valid on the first beat only
    logic [ADDR_W-1:0]      address;
    logic [DATA_W-1:0]      writedata;
  } avl_cmd_t;

  // Read data beat back from the slave
  typedef struct packed {
    logic              readdatavalid;  // One-cycle strobe
    logic [DATA_W-1:0] readdata;
  } avl_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master slot occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic {
    SLOT_EMPTY = 1'b0,  // Free, may be loaded
    SLOT_FULL  = 1'b1   // Holding a command for the arbiter
  } slot_state_e;

endpackage

// File: rtl/avl_bus_priority_encoder.sv
module avl_bus_priority_encoder #(
  parameter int SIGN_WIDTH = 8  // Request vector width, at least 2
) (
  input  logic [SIGN_WIDTH-1:0]         in,
  output logic [$clog2(SIGN_WIDTH)-1:0] out
);

  localparam int OUT_W = $clog2(SIGN_WIDTH);

  // Scan from the top down so the lowest set bit wins last
  always_comb begin
    out = '0;  // No request gives index zero
    for (int i = SIGN_WIDTH - 1; i >= 0; i--) begin
      if (in[i]) begin
        out = OUT_W'(i);
      end
    end
  end

endmodule

// File: rtl/avl_bus_rsp_router.sv
`include "avl_bus_macros.svh"

module avl_bus_rsp_router #(
  parameter int MASTER_NUM = `AVL_MASTER_NUM
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic                          owner_push,  // Read accepted downstream
  input  logic [$clog2(MASTER_NUM)-1:0] owner_id,
  input  avl_bus_pkg::avl_rsp_t         s_rsp,
  output avl_bus_pkg::avl_rsp_t         rsp_out [MASTER_NUM]
);

  localparam int DEPTH = `AVL_OWNER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int ID_W  = $clog2(MASTER_NUM);

  logic [ID_W-1:0]  owner_mem [DEPTH];  // Issuers in command order
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;
  logic [ID_W-1:0]  head_id;

  assign pop     = s_rsp.readdatavalid;  // Every returning beat retires one owner
  assign head_id = owner_mem[rd_ptr];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Owner FIFO
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (owner_push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      if (pop)        rd_ptr <= rd_ptr + 1'b1;
      if (owner_push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !owner_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (owner_push) begin
      owner_mem[wr_ptr] <= owner_id;
    end
  end

  // Broadcast data, strobe only the owner
  always_comb begin
    for (int i = 0; i < MASTER_NUM; i++) begin
      rsp_out[i].readdatavalid = pop && (head_id == ID_W'(i));
      rsp_out[i].readdata      = s_rsp.readdata;
    end
  end

  // Slave returned data for a read never issued
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rest)
    pop |-> (count != '0))
    else $error("rsp_router: response with no owner");

  // Too many reads in flight for the owner FIFO
  a_no_push_full: assert property (@(posedge clk) disable iff (!rest)
    owner_push |-> (count != (PTR_W+1)'(DEPTH)))
    else $error("rsp_router: owner FIFO overflow");

endmodule
